// File: source/dbg_layout_pkg.sv
package dbg_layout_pkg;

  //////////////////////////////////////////////////////////////////////
  // Basic widths
  //////////////////////////////////////////////////////////////////////

  localparam int BYTE_W         = 8;                      // Serial output width
  localparam int WORD_W         = 32;                     // Processor word
  localparam int BYTES_PER_WORD = WORD_W / BYTE_W;        // 4 lanes per word
  localparam int LANE_W         = $clog2(BYTES_PER_WORD); // Byte lane select bits

  //////////////////////////////////////////////////////////////////////
  // Snapshot contents
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_GPR       = 8; // Registers 0..7 only
  localparam int NUM_MEM_WORDS = 2; // Data memory words 0..1

  // Word positions inside the snapshot, in dump order
  localparam int IDX_GPR0    = 0;                  // First general register
  localparam int IDX_CTRL    = IDX_GPR0 + NUM_GPR; // Packed control word, 8
  localparam int IDX_POST_PC = IDX_CTRL + 1;       // 9
  localparam int IDX_INSTR   = IDX_POST_PC + 1;    // 10
  localparam int IDX_MEM0    = IDX_INSTR + 1;      // 11

  localparam int NUM_WORDS = IDX_MEM0 + NUM_MEM_WORDS;    // 13 words
  localparam int NUM_BYTES = NUM_WORDS * BYTES_PER_WORD;  // 52 bytes

  //////////////////////////////////////////////////////////////////////
  // Read pointer
  //////////////////////////////////////////////////////////////////////

  localparam int PTR_W  = $clog2(NUM_BYTES); // 6 bits covers 0..51
  localparam int WIDX_W = PTR_W - LANE_W;    // Upper pointer bits pick the word

endpackage

// File: source/dbg_ctrl_pkg.sv
package dbg_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Tag constants
  //////////////////////////////////////////////////////////////////////

  // Fixed markers so a host can spot the control bytes in the dump
  localparam logic [2:0] TAG_IDEX1 = 3'b101;   // ID/EX one-bit controls
  localparam logic [2:0] TAG_EX    = 3'b010;   // EX stage controls
  localparam logic [4:0] TAG_MEM   = 5'b00110; // MEM stage controls

  //////////////////////////////////////////////////////////////////////
  // Control bytes
  //////////////////////////////////////////////////////////////////////

  // ID/EX two-bit controls, no tag
  typedef struct packed {
    logic [1:0] pad;        // Always zero
    logic [1:0] reg_dst;
    logic [1:0] mem_to_reg;
    logic [1:0] alu_op;
  } ctrl_idex2_t;

  // ID/EX one-bit controls
  typedef struct packed {
    logic [2:0] tag;        // TAG_IDEX1
    logic       branch;
    logic       mem_read;
    logic       mem_write;
    logic       alu_src;
    logic       reg_write;
  } ctrl_idex1_t;

  typedef struct packed {
    logic [2:0] tag;        // TAG_EX
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic [1:0] mem_to_reg;
  } ctrl_ex_t;

  typedef struct packed {
    logic [4:0] tag;        // TAG_MEM
    logic       reg_write;
    logic [1:0] mem_to_reg;
  } ctrl_mem_t;

  // Byte order as dumped, idex2 goes out first
  typedef struct packed {
    ctrl_idex2_t idex2;     // Bits 31:24
    ctrl_idex1_t idex1;     // Bits 23:16
    ctrl_ex_t    ex;        // Bits 15:8
    ctrl_mem_t   mem;       // Bits 7:0
  } ctrl_fields_t;

  // Filled by field, shipped as a plain word
  typedef union packed {
    ctrl_fields_t                        fields;
    logic [dbg_layout_pkg::WORD_W-1:0] raw;
  } ctrl_word_t;

endpackage

// File: source/snapshot_capture.sv
module snapshot_capture (
  input  logic                                                        clk,
  input  logic                                                        rst_n,
  input  logic                                                        capture,
  input  logic                                                        empty,
  // Register file
  input  logic [dbg_layout_pkg::NUM_GPR-1:0][dbg_layout_pkg::WORD_W-1:0] gpr,
  // ID/EX controls
  input  logic                                                        branch_id,
  input  logic                                                        mem_read_id,
  input  logic                                                        mem_write_id,
  input  logic                                                        alu_src_id,
  input  logic                                                        reg_write_id,
  input  logic [1:0]                                                  reg_dst_id,
  input  logic [1:0]                                                  mem_to_reg_id,
  input  logic [1:0]                                                  alu_op_id,
  // EX stage controls
  input  logic                                                        mem_read_ex,
  input  logic                                                        mem_write_ex,
  input  logic                                                        reg_write_ex,
  input  logic [1:0]                                                  mem_to_reg_ex,
  // MEM stage controls
  input  logic                                                        reg_write_mem,
  input  logic [1:0]                                                  mem_to_reg_mem,
  // Fetch state
  input  logic [dbg_layout_pkg::WORD_W-1:0]                           post_pc,
  input  logic [dbg_layout_pkg::WORD_W-1:0]                           instruction,
  // Data memory
  input  logic [dbg_layout_pkg::NUM_MEM_WORDS-1:0][dbg_layout_pkg::WORD_W-1:0] mem_word,
  output logic [dbg_layout_pkg::NUM_WORDS-1:0][dbg_layout_pkg::WORD_W-1:0] snap_words,
  output logic                                                        snap_loaded
);

  dbg_ctrl_pkg::ctrl_word_t ctrl_word; // Four tagged control bytes
  logic                     accept;    // Capture taken this edge

  //////////////////////////////////////////////////////////////////////
  // Control word assembly
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    ctrl_word.fields.idex2.pad        = 2'b00;               // Top bits stay clear
    ctrl_word.fields.idex2.reg_dst    = reg_dst_id;
    ctrl_word.fields.idex2.mem_to_reg = mem_to_reg_id;
    ctrl_word.fields.idex2.alu_op     = alu_op_id;

    ctrl_word.fields.idex1.tag        = dbg_ctrl_pkg::TAG_IDEX1;
    ctrl_word.fields.idex1.branch     = branch_id;
    ctrl_word.fields.idex1.mem_read   = mem_read_id;
    ctrl_word.fields.idex1.mem_write  = mem_write_id;
    ctrl_word.fields.idex1.alu_src    = alu_src_id;
    ctrl_word.fields.idex1.reg_write  = reg_write_id;

    ctrl_word.fields.ex.tag           = dbg_ctrl_pkg::TAG_EX;
    ctrl_word.fields.ex.mem_read      = mem_read_ex;
    ctrl_word.fields.ex.mem_write     = mem_write_ex;
    ctrl_word.fields.ex.reg_write     = reg_write_ex;
    ctrl_word.fields.ex.mem_to_reg    = mem_to_reg_ex;

    ctrl_word.fields.mem.tag          = dbg_ctrl_pkg::TAG_MEM;
    ctrl_word.fields.mem.reg_write    = reg_write_mem;
    ctrl_word.fields.mem.mem_to_reg   = mem_to_reg_mem;
  end

  // Only an idle buffer takes a new picture
  assign accept = capture && empty;

  //////////////////////////////////////////////////////////////////////
  // Snapshot store
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      for (int i = 0; i < dbg_layout_pkg::NUM_GPR; i++)
      begin
        snap_words[dbg_layout_pkg::IDX_GPR0 + i] <= gpr[i]; // Registers 0..7
      end
      snap_words[dbg_layout_pkg::IDX_CTRL]    <= ctrl_word.raw;
      snap_words[dbg_layout_pkg::IDX_POST_PC] <= post_pc;
      snap_words[dbg_layout_pkg::IDX_INSTR]   <= instruction;
      for (int j = 0; j < dbg_layout_pkg::NUM_MEM_WORDS; j++)
      begin
        snap_words[dbg_layout_pkg::IDX_MEM0 + j] <= mem_word[j]; // Memory words last
      end
    end
  end

  // One-cycle strobe that starts the serializer
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      snap_loaded <= 1'b0;
    else
      snap_loaded <= accept;
  end

endmodule

// File: source/snapshot_serializer.sv
module snapshot_serializer (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  logic                                                          snap_loaded,
  input  logic                                                          rd,
  input  logic [dbg_layout_pkg::NUM_WORDS-1:0][dbg_layout_pkg::WORD_W-1:0] snap_words,
  output logic [dbg_layout_pkg::BYTE_W-1:0]                             r_data,
  output logic                                                          empty
);

  logic [dbg_layout_pkg::PTR_W-1:0]  ptr;      // Next byte to hand out
  logic [dbg_layout_pkg::WIDX_W-1:0] word_idx; // Word under the pointer
  logic [dbg_layout_pkg::LANE_W-1:0] lane;     // Byte lane, 0 is the MSB lane
  logic [dbg_layout_pkg::WORD_W-1:0] cur_word;
  logic                              rd_ok;    // Accepted read strobe
  logic                              last_byte;

  assign rd_ok     = rd && !empty;
  assign last_byte = (ptr == dbg_layout_pkg::PTR_W'(dbg_layout_pkg::NUM_BYTES - 1));

  //////////////////////////////////////////////////////////////////////
  // Pointer and empty flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ptr   <= '0;
      empty <= 1'b1;                 // Nothing to read out of reset
    end
    else if (snap_loaded && empty)
    begin
      ptr   <= '0;                   // Fresh picture starts at byte 0
      empty <= 1'b0;
    end
    else if (rd_ok)
    begin
      if (last_byte)
      begin
        ptr   <= '0;                 // Park at 0 for the next dump
        empty <= 1'b1;
      end
      else
      begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Byte select
  //////////////////////////////////////////////////////////////////////

  assign word_idx = ptr[dbg_layout_pkg::PTR_W-1:dbg_layout_pkg::LANE_W];
  assign lane     = ptr[dbg_layout_pkg::LANE_W-1:0];
  assign cur_word = snap_words[word_idx];

  // Lane 0 maps to bits 31:24, so each word leaves MSB first
  always_comb
  begin
    r_data = '0;
    for (int k = 0; k < dbg_layout_pkg::BYTES_PER_WORD; k++)
    begin
      if (lane == dbg_layout_pkg::LANE_W'(k))
        r_data = cur_word[(dbg_layout_pkg::BYTES_PER_WORD - 1 - k) * dbg_layout_pkg::BYTE_W
                          +: dbg_layout_pkg::BYTE_W];
    end
  end

endmodule

// File: source/pipeline_debug_dump.sv
module pipeline_debug_dump (
  input  logic                                                        clk,
  input  logic                                                        rst_n,
  input  logic                                                        capture,
  input  logic                                                        rd,
  input  logic [dbg_layout_pkg::NUM_GPR-1:0][dbg_layout_pkg::WORD_W-1:0] gpr,
  input  logic                                                        branch_id,
  input  logic                                                        mem_read_id,
  input  logic                                                        mem_write_id,
  input  logic                                                        alu_src_id,
  input  logic                                                        reg_write_id,
  input  logic [1:0]                                                  reg_dst_id,
  input  logic [1:0]                                                  mem_to_reg_id,
  input  logic [1:0]                                                  alu_op_id,
  input  logic                                                        mem_read_ex,
  input  logic                                                        mem_write_ex,
  input  logic                                                        reg_write_ex,
  input  logic [1:0]                                                  mem_to_reg_ex,
  input  logic                                                        reg_write_mem,
  input  logic [1:0]                                                  mem_to_reg_mem,
  input  logic [dbg_layout_pkg::WORD_W-1:0]                           post_pc,
  input  logic [dbg_layout_pkg::WORD_W-1:0]                           instruction,
  input  logic [dbg_layout_pkg::NUM_MEM_WORDS-1:0][dbg_layout_pkg::WORD_W-1:0] mem_word,
  output logic [dbg_layout_pkg::BYTE_W-1:0]                           r_data,
  output logic                                                        empty
);

  //////////////////////////////////////////////////////////////////////
  // Stage to stage wires
  //////////////////////////////////////////////////////////////////////

  logic [dbg_layout_pkg::NUM_WORDS-1:0][dbg_layout_pkg::WORD_W-1:0] snap_words; // Frozen picture
  logic                                                            snap_loaded; // New picture

  // Stage 1, freezes the machine state
  snapshot_capture i_capture (
    .clk            (clk),
    .rst_n          (rst_n),
    .capture        (capture),
    .empty          (empty),          // Gates new captures
    .gpr            (gpr),
    .branch_id      (branch_id),
    .mem_read_id    (mem_read_id),
    .mem_write_id   (mem_write_id),
    .alu_src_id     (alu_src_id),
    .reg_write_id   (reg_write_id),
    .reg_dst_id     (reg_dst_id),
    .mem_to_reg_id  (mem_to_reg_id),
    .alu_op_id      (alu_op_id),
    .mem_read_ex    (mem_read_ex),
    .mem_write_ex   (mem_write_ex),
    .reg_write_ex   (reg_write_ex),
    .mem_to_reg_ex  (mem_to_reg_ex),
    .reg_write_mem  (reg_write_mem),
    .mem_to_reg_mem (mem_to_reg_mem),
    .post_pc        (post_pc),
    .instruction    (instruction),
    .mem_word       (mem_word),
    .snap_words     (snap_words),
    .snap_loaded    (snap_loaded)
  );

  // Stage 2, byte stream out
  snapshot_serializer i_serializer (
    .clk         (clk),
    .rst_n       (rst_n),
    .snap_loaded (snap_loaded),
    .rd          (rd),
    .snap_words  (snap_words),
    .r_data      (r_data),
    .empty       (empty)
  );

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 5; // 10 ns clock
  localparam int RESET_CYCLES = 3;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset held over three rising edges, released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: tb/debug_dump_assertions.sv
module debug_dump_assertions (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              snap_loaded,
  input logic                              rd,
  input logic                              empty,
  input logic [dbg_layout_pkg::BYTE_W-1:0] r_data
);

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////////////////////////
  // Serializer properties
  //////////////////////////////////////////////////////////////////////

  // Synchronous reset leaves the buffer with nothing to read
  reset_empty: assert property (@(posedge clk) !rst_n |=> empty)
    else $error("empty is not high after a reset edge");

  // Pointer only moves on an accepted read
  hold_r_data: assert property (@(posedge clk) disable iff (!rst_n)
                                (!rd && !empty) |=> $stable(r_data))
    else $error("r_data changed while no read was requested");

  // A dump starts only from a loaded snapshot
  empty_fall: assert property (@(posedge clk) disable iff (!rst_n)
                               $fell(empty) |-> $past(snap_loaded))
    else $error("empty fell without a snap_loaded pulse one cycle earlier");

endmodule

bind snapshot_serializer debug_dump_assertions i_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .snap_loaded (snap_loaded),
  .rd          (rd),
  .empty       (empty),
  .r_data      (r_data)
);

// File: tb/tb_pipeline_debug_dump.sv
module tb_pipeline_debug_dump;

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////////////////////////
  // Test table
  //////////////////////////////////////////////////////////////////////

  localparam int          NUM_CASES = 6;
  localparam int          NUM_BYTES = dbg_layout_pkg::NUM_BYTES;
  localparam int          MID_BYTE  = 21;            // Read position of the ignored capture
  localparam logic [31:0] LCG_SEED  = 32'd64962;
  localparam int          WATCHDOG_CYCLES = NUM_CASES * (NUM_BYTES + 10)
                                            + NUM_CASES * NUM_BYTES + 100; // Idle cycle margin

  // Bits 18:14 branch, mem_read, mem_write, alu_src, reg_write of ID/EX
  // Bits 13:8 reg_dst, mem_to_reg, alu_op of ID/EX
  // Bits 7:3 mem_read, mem_write, reg_write, mem_to_reg of EX
  // Bits 2:0 reg_write, mem_to_reg of MEM
  localparam logic [18:0] CASE_CTRL [NUM_CASES] = '{
    19'h00000, 19'h7FFFF, 19'h5A5A5, 19'h2A5C3, 19'h41B6E, 19'h3C00F
  };
  localparam logic [31:0] CASE_SEED_OFS [NUM_CASES] = '{
    32'd0, 32'd17, 32'd301, 32'd4099, 32'd65537, 32'd777
  };
  localparam bit CASE_MID_CAPTURE [NUM_CASES] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};

  logic                                                                    clk;
  logic                                                                    rst_n;
  logic                                                                    capture;
  logic                                                                    rd;
  logic [dbg_layout_pkg::NUM_GPR-1:0][dbg_layout_pkg::WORD_W-1:0]         gpr;
  logic                                                                    branch_id;
  logic                                                                    mem_read_id;
  logic                                                                    mem_write_id;
  logic                                                                    alu_src_id;
  logic                                                                    reg_write_id;
  logic [1:0]                                                              reg_dst_id;
  logic [1:0]                                                              mem_to_reg_id;
  logic [1:0]                                                              alu_op_id;
  logic                                                                    mem_read_ex;
  logic                                                                    mem_write_ex;
  logic                                                                    reg_write_ex;
  logic [1:0]                                                              mem_to_reg_ex;
  logic                                                                    reg_write_mem;
  logic [1:0]                                                              mem_to_reg_mem;
  logic [31:0]                                                             post_pc;
  logic [31:0]                                                             instruction;
  logic [dbg_layout_pkg::NUM_MEM_WORDS-1:0][dbg_layout_pkg::WORD_W-1:0]   mem_word;
  logic [7:0]                                                              r_data;
  logic                                                                    empty;

  logic [31:0] exp_words [dbg_layout_pkg::NUM_WORDS]; // Reference picture
  logic [31:0] lcg_state;
  int          mismatch_count;
  int          failure_count;

  tb_clock_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  pipeline_debug_dump i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .capture        (capture),
    .rd             (rd),
    .gpr            (gpr),
    .branch_id      (branch_id),
    .mem_read_id    (mem_read_id),
    .mem_write_id   (mem_write_id),
    .alu_src_id     (alu_src_id),
    .reg_write_id   (reg_write_id),
    .reg_dst_id     (reg_dst_id),
    .mem_to_reg_id  (mem_to_reg_id),
    .alu_op_id      (alu_op_id),
    .mem_read_ex    (mem_read_ex),
    .mem_write_ex   (mem_write_ex),
    .reg_write_ex   (reg_write_ex),
    .mem_to_reg_ex  (mem_to_reg_ex),
    .reg_write_mem  (reg_write_mem),
    .mem_to_reg_mem (mem_to_reg_mem),
    .post_pc        (post_pc),
    .instruction    (instruction),
    .mem_word       (mem_word),
    .r_data         (r_data),
    .empty          (empty)
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes LCG
    return lcg_state;
  endfunction

  task automatic apply_state(input logic [18:0] ctrl);
    {branch_id, mem_read_id, mem_write_id, alu_src_id, reg_write_id} = ctrl[18:14];
    {reg_dst_id, mem_to_reg_id, alu_op_id} = ctrl[13:8];
    {mem_read_ex, mem_write_ex, reg_write_ex, mem_to_reg_ex} = ctrl[7:3];
    {reg_write_mem, mem_to_reg_mem} = ctrl[2:0];
    for (int i = 0; i < dbg_layout_pkg::NUM_GPR; i++)
      gpr[i] = next_random();
    post_pc     = next_random();
    instruction = next_random();
    for (int j = 0; j < dbg_layout_pkg::NUM_MEM_WORDS; j++)
      mem_word[j] = next_random();
  endtask

  // Registers, control, post PC, instruction, memory
  task automatic build_expected();
    for (int i = 0; i < 8; i++)
      exp_words[i] = gpr[i];
    exp_words[8] = {2'b00, reg_dst_id, mem_to_reg_id, alu_op_id,                   // Pad, no tag
                    3'b101, branch_id, mem_read_id, mem_write_id, alu_src_id, reg_write_id,
                    3'b010, mem_read_ex, mem_write_ex, reg_write_ex, mem_to_reg_ex,
                    5'b00110, reg_write_mem, mem_to_reg_mem};
    exp_words[9]  = post_pc;
    exp_words[10] = instruction;
    exp_words[11] = mem_word[0];
    exp_words[12] = mem_word[1];
  endtask

  function automatic logic [7:0] expected_byte(input int n);
    logic [31:0] w;
    w = exp_words[n / 4];
    return w[31 - 8 * (n % 4) -: 8];                // MSB lane first
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_byte(input int n);
    logic [7:0] exp;
    exp = expected_byte(n);
    assert (r_data === exp)
    else
    begin
      mismatch_count++;
      $display("mismatch at %0t: r_data byte %0d got %02h expected %02h", $time, n, r_data, exp);
    end
  endtask

  task automatic check_empty(input logic exp, input string where);
    assert (empty === exp)
    else
    begin
      mismatch_count++;
      $display("mismatch at %0t: empty got %b expected %b %s", $time, empty, exp, where);
    end
  endtask

  // One-cycle strobe, then wait for the dump to open
  task automatic capture_snapshot();
    int cycles;
    capture = 1'b1;
    @(negedge clk);
    capture = 1'b0;
    cycles  = 1;
    while (empty && cycles < 4)
    begin
      @(negedge clk);
      cycles++;
    end
    assert (!empty && cycles <= 2)
    else
    begin
      failure_count++;
      $display("error at %0t: empty did not fall within 2 cycles of a capture", $time);
    end
  endtask

  task automatic read_dump(input int c);
    logic [31:0] coin;
    for (int n = 0; n < NUM_BYTES; n++)
    begin
      check_empty(1'b0, "during dump");
      check_byte(n);
      rd = 1'b1;
      if (CASE_MID_CAPTURE[c] && n == MID_BYTE)
      begin
        apply_state(~CASE_CTRL[c]);               // New state must be ignored
        capture = 1'b1;
      end
      @(negedge clk);
      rd      = 1'b0;
      capture = 1'b0;
      coin    = next_random();
      if (coin[5:3] == 3'd0)
        @(negedge clk);                           // Occasional idle cycle
    end
    check_empty(1'b1, "after last read");
  endtask

  task automatic report_counts();
    $display("checks done: %0d mismatches, %0d other failures", mismatch_count, failure_count);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    mismatch_count = 0;
    failure_count  = 0;
    lcg_state      = LCG_SEED;
    capture        = 1'b0;
    rd             = 1'b0;
    apply_state('0);
    @(posedge rst_n);
    check_empty(1'b1, "after reset");
    rd = 1'b1;                                      // Read of an empty buffer
    @(negedge clk);
    rd = 1'b0;
    @(negedge clk);
    check_empty(1'b1, "after rd while empty");
    for (int c = 0; c < NUM_CASES; c++)
    begin
      lcg_state = LCG_SEED + CASE_SEED_OFS[c];
      apply_state(CASE_CTRL[c]);
      build_expected();
      capture_snapshot();
      read_dump(c);
      rd = 1'b1;
      @(negedge clk);
      rd = 1'b0;
      check_empty(1'b1, "after extra rd");
    end
    report_counts();
    if (mismatch_count + failure_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    report_counts();
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: verilog.f
source/dbg_layout_pkg.sv
source/dbg_ctrl_pkg.sv
source/snapshot_capture.sv
source/snapshot_serializer.sv
source/pipeline_debug_dump.sv
tb/tb_clock_gen.sv
tb/debug_dump_assertions.sv
tb/tb_pipeline_debug_dump.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the log

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_pipeline_debug_dump
BUILD_DIR=obj_dir
LOG_FILE=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module "$TOP" -Mdir "$BUILD_DIR" -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG_FILE"; then
  echo "simulation reported failures, see $LOG_FILE"
  exit 1
fi

echo "simulation finished without failures"
exit 0
